// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f project.f \
		--top-module tb_branch_unit

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
		--top-module tb_branch_unit -Mdir obj_dir -o tb_branch_unit
	./obj_dir/tb_branch_unit > sim.log 2>&1 || true
	cat sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== branch_cond_pkg.sv ====
// Branch condition types

package branch_cond_pkg;

    // ----------------------------------------
    // Flags
    // ----------------------------------------
    // The first field sits in the most significant bit.
    typedef struct packed {
        logic zero;                 // Result was zero.
        logic negative;             // Result sign bit.
        logic carry;                // Carry out of the adder.
        logic overflow;             // Signed overflow.
    } flags_t;

    // ----------------------------------------
    // Condition codes
    // ----------------------------------------
    typedef enum logic [2:0] {
        COND_NEVER        = 3'd0,   // Never taken.
        COND_ALWAYS       = 3'd1,   // Always taken.
        COND_ZERO         = 3'd2,   // Taken when zero is set.
        COND_NOT_ZERO     = 3'd3,   // Taken when zero is clear.
        COND_NEGATIVE     = 3'd4,   // Taken when negative is set.
        COND_NOT_NEGATIVE = 3'd5,   // Taken when negative is clear.
        COND_CARRY        = 3'd6,   // Taken when carry is set.
        COND_OVERFLOW     = 3'd7    // Taken when overflow is set.
    } cond_t;

    localparam int COND_WIDTH  = $bits(cond_t);    // Condition field width in a write word.
    localparam int FLAGS_WIDTH = $bits(flags_t);   // Flag bus width.

    // A cleared store reads as never, so reset disables every entry.
    localparam cond_t COND_RESET = COND_NEVER;

endpackage

// ==== branch_defs.svh ====
// Branch unit parameters
`ifndef BRANCH_DEFS_SVH
`define BRANCH_DEFS_SVH

// ----------------------------------------
// Threads and entries
// ----------------------------------------
`define BR_THREAD_COUNT  8          // Hardware threads, issued round-robin.
`define BR_ENTRY_COUNT   4          // Branch entries held for each thread.

// ----------------------------------------
// Widths
// ----------------------------------------
`define BR_PC_WIDTH      10         // Program counter width.
`define BR_ADDR_WIDTH    12         // Data-memory write address width.
`define BR_WORD_WIDTH    16         // Data-memory write word width.

// ----------------------------------------
// Memory map
// ----------------------------------------
// Each window spans BR_ENTRY_COUNT addresses, one per entry.
`define BR_ORIGIN_BASE   12'h100    // Origin PC window.
`define BR_DEST_BASE     12'h104    // Destination PC window.
`define BR_COND_BASE     12'h108    // Condition code window.

// Low bit of each field inside the write word.
`define BR_ORIGIN_OFFSET 0
`define BR_DEST_OFFSET   0
`define BR_COND_OFFSET   0

`endif

// ==== branch_entry.sv ====
// Single branch entry
`timescale 1ns/1ps

module branch_entry
    import branch_map_pkg::*, branch_cond_pkg::*;
(
    input  logic    clock,
    input  logic    rst_n,
    input  thread_t current_thread,
    input  logic    origin_we,
    input  logic    dest_we,
    input  logic    cond_we,
    input  pc_t     origin_data,
    input  pc_t     dest_data,
    input  cond_t   cond_data,
    input  pc_t     pc,                     // PC of the issuing thread.
    input  flags_t  flags,                  // Flags of the issuing thread.
    input  logic    io_ready,               // Issuing instruction may proceed.
    output logic    match,
    output pc_t     dest
);

    // ----------------------------------------
    // Field stores
    // ----------------------------------------
    pc_t   origin_q;
    pc_t   dest_q;
    cond_t cond_q;

    thread_field_store #(.payload_t(pc_t)) i_origin_store (
        .clock  (clock),
        .rst_n  (rst_n),
        .we     (origin_we),
        .thread (current_thread),
        .wdata  (origin_data),
        .rdata  (origin_q)
    );

    thread_field_store #(.payload_t(pc_t)) i_dest_store (
        .clock  (clock),
        .rst_n  (rst_n),
        .we     (dest_we),
        .thread (current_thread),
        .wdata  (dest_data),
        .rdata  (dest_q)
    );

    thread_field_store #(.payload_t(cond_t)) i_cond_store (
        .clock  (clock),
        .rst_n  (rst_n),
        .we     (cond_we),
        .thread (current_thread),
        .wdata  (cond_data),
        .rdata  (cond_q)
    );

    // ----------------------------------------
    // Condition and origin compare
    // ----------------------------------------
    logic cond_ok;

    always_comb begin
        cond_ok = 1'b0;
        unique case (cond_q)
            COND_NEVER:        cond_ok = 1'b0;
            COND_ALWAYS:       cond_ok = 1'b1;
            COND_ZERO:         cond_ok = flags.zero;
            COND_NOT_ZERO:     cond_ok = !flags.zero;
            COND_NEGATIVE:     cond_ok = flags.negative;
            COND_NOT_NEGATIVE: cond_ok = !flags.negative;
            COND_CARRY:        cond_ok = flags.carry;
            COND_OVERFLOW:     cond_ok = flags.overflow;
        endcase
    end

    assign match = io_ready && (origin_q == pc) && cond_ok;     // Stalled issue never jumps.
    assign dest  = dest_q;

endmodule

// ==== branch_map_decoder.sv ====
// Thread sequencer and write decoder
`timescale 1ns/1ps
`include "branch_defs.svh"

module branch_map_decoder
    import branch_map_pkg::*, branch_cond_pkg::*;
(
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       wr_en,
    input  waddr_t                     wr_addr,
    input  wdata_t                     wr_data,
    output thread_t                    current_thread,
    output logic [`BR_ENTRY_COUNT-1:0] origin_we,
    output logic [`BR_ENTRY_COUNT-1:0] dest_we,
    output logic [`BR_ENTRY_COUNT-1:0] cond_we,
    output pc_t                        origin_data,
    output pc_t                        dest_data,
    output cond_t                      cond_data
);

    // ----------------------------------------
    // Thread sequencer
    // ----------------------------------------
    thread_t thread_q;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            thread_q <= '0;                                     // Thread 0 issues first.
        end else if (thread_q == thread_t'(`BR_THREAD_COUNT - 1)) begin
            thread_q <= '0;
        end else begin
            thread_q <= thread_q + thread_t'(1);
        end
    end

    assign current_thread = thread_q;

    // ----------------------------------------
    // Window decode
    // ----------------------------------------
    function automatic logic [`BR_ENTRY_COUNT-1:0] window_decode(
        input logic   en,
        input waddr_t addr,
        input waddr_t base
    );
        waddr_t                     offset;
        logic [`BR_ENTRY_COUNT-1:0] onehot;
        offset = addr - base;                                   // Entry index within the window.
        onehot = '0;
        if (en && (addr >= base) && (offset < waddr_t'(`BR_ENTRY_COUNT))) begin
            onehot[entry_idx_t'(offset)] = 1'b1;
        end
        return onehot;
    endfunction

    assign origin_we = window_decode(wr_en, wr_addr, `BR_ORIGIN_BASE);
    assign dest_we   = window_decode(wr_en, wr_addr, `BR_DEST_BASE);
    assign cond_we   = window_decode(wr_en, wr_addr, `BR_COND_BASE);

    // ----------------------------------------
    // Field slices
    // ----------------------------------------
    assign origin_data = wr_data[`BR_ORIGIN_OFFSET +: `BR_PC_WIDTH];
    assign dest_data   = wr_data[`BR_DEST_OFFSET +: `BR_PC_WIDTH];
    assign cond_data   = cond_t'(wr_data[`BR_COND_OFFSET +: COND_WIDTH]);

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    // The three windows must not overlap, so one write reaches one field.
    a_one_field_write: assert property (
        @(posedge clock) disable iff (!rst_n)
        $onehot0({origin_we, dest_we, cond_we})
    ) else $error("Write decoded into more than one field.");

endmodule

// ==== branch_map_pkg.sv ====
// Branch unit memory map types
`include "branch_defs.svh"

package branch_map_pkg;

    // ----------------------------------------
    // Program counter
    // ----------------------------------------
    typedef logic [`BR_PC_WIDTH-1:0] pc_t;                  // Origin and destination PCs.

    // ----------------------------------------
    // Thread and entry indices
    // ----------------------------------------
    localparam int THREAD_IDX_WIDTH = $clog2(`BR_THREAD_COUNT);
    localparam int ENTRY_IDX_WIDTH  = $clog2(`BR_ENTRY_COUNT);

    typedef logic [THREAD_IDX_WIDTH-1:0] thread_t;          // Issuing thread number.
    typedef logic [ENTRY_IDX_WIDTH-1:0]  entry_idx_t;       // Entry within one thread.

    // ----------------------------------------
    // Data-memory write port
    // ----------------------------------------
    typedef logic [`BR_ADDR_WIDTH-1:0] waddr_t;             // Write address.
    typedef logic [`BR_WORD_WIDTH-1:0] wdata_t;             // Write word.

    // The origin and destination fields must fit in the write word.
    localparam int ORIGIN_TOP = `BR_ORIGIN_OFFSET + `BR_PC_WIDTH;
    localparam int DEST_TOP   = `BR_DEST_OFFSET + `BR_PC_WIDTH;

    typedef logic [ORIGIN_TOP-1:0] origin_span_t;           // Word bits up to the origin field.
    typedef logic [DEST_TOP-1:0]   dest_span_t;             // Word bits up to the destination field.

endpackage

// ==== branch_select.sv ====
// Branch priority select
`timescale 1ns/1ps
`include "branch_defs.svh"

module branch_select
    import branch_map_pkg::*;
(
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic [`BR_ENTRY_COUNT-1:0] match,
    input  pc_t                        dest [`BR_ENTRY_COUNT],
    output logic                       jump,
    output pc_t                        jump_dest
);

    // ----------------------------------------
    // Priority select
    // ----------------------------------------
    pc_t  sel_dest;
    logic any_match;

    // Scanning downward leaves the lowest matching entry in place.
    always_comb begin
        sel_dest = '0;
        for (int i = `BR_ENTRY_COUNT - 1; i >= 0; i--) begin
            if (match[i]) begin
                sel_dest = dest[i];
            end
        end
    end

    assign any_match = |match;

    // ----------------------------------------
    // Output registers
    // ----------------------------------------
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            jump      <= 1'b0;
            jump_dest <= '0;
        end else begin
            jump <= any_match;                      // One cycle after the compare.
            if (any_match) begin
                jump_dest <= sel_dest;              // Held while no entry matches.
            end
        end
    end

    // The destination only moves together with a taken jump.
    a_dest_with_jump: assert property (
        @(posedge clock) disable iff (!rst_n)
        $changed(jump_dest) |-> jump
    ) else $error("Destination changed without a jump.");

endmodule

// ==== branch_unit.sv ====
// Multithreaded branch unit
`timescale 1ns/1ps
`include "branch_defs.svh"

module branch_unit
    import branch_map_pkg::*, branch_cond_pkg::*;
(
    input  logic   clock,
    input  logic   rst_n,
    input  pc_t    pc,
    input  flags_t flags,
    input  logic   io_ready,
    input  logic   wr_en,
    input  waddr_t wr_addr,
    input  wdata_t wr_data,
    output logic   jump,
    output pc_t    jump_dest
);

    // ----------------------------------------
    // Decoder
    // ----------------------------------------
    thread_t                    current_thread;
    logic [`BR_ENTRY_COUNT-1:0] origin_we;
    logic [`BR_ENTRY_COUNT-1:0] dest_we;
    logic [`BR_ENTRY_COUNT-1:0] cond_we;
    pc_t                        origin_data;
    pc_t                        dest_data;
    cond_t                      cond_data;

    branch_map_decoder i_decoder (
        .clock          (clock),
        .rst_n          (rst_n),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .current_thread (current_thread),
        .origin_we      (origin_we),
        .dest_we        (dest_we),
        .cond_we        (cond_we),
        .origin_data    (origin_data),
        .dest_data      (dest_data),
        .cond_data      (cond_data)
    );

    // ----------------------------------------
    // Entries
    // ----------------------------------------
    logic [`BR_ENTRY_COUNT-1:0] match;
    pc_t                        dest [`BR_ENTRY_COUNT];

    for (genvar e = 0; e < `BR_ENTRY_COUNT; e++) begin : g_entry
        branch_entry i_entry (
            .clock          (clock),
            .rst_n          (rst_n),
            .current_thread (current_thread),
            .origin_we      (origin_we[e]),
            .dest_we        (dest_we[e]),
            .cond_we        (cond_we[e]),
            .origin_data    (origin_data),
            .dest_data      (dest_data),
            .cond_data      (cond_data),
            .pc             (pc),
            .flags          (flags),
            .io_ready       (io_ready),
            .match          (match[e]),
            .dest           (dest[e])
        );
    end

    // ----------------------------------------
    // Select
    // ----------------------------------------
    branch_select i_select (
        .clock     (clock),
        .rst_n     (rst_n),
        .match     (match),
        .dest      (dest),
        .jump      (jump),
        .jump_dest (jump_dest)
    );

endmodule

// ==== project.f ====
+incdir+.
branch_map_pkg.sv
branch_cond_pkg.sv
thread_field_store.sv
branch_map_decoder.sv
branch_entry.sv
branch_select.sv
branch_unit.sv
tb_branch_unit.sv

// ==== tb_branch_unit.sv ====
// Branch unit testbench
`timescale 1ns/1ps
`include "branch_defs.svh"

module tb_branch_unit
    import branch_map_pkg::*, branch_cond_pkg::*;
();

    localparam int     TIMEOUT_CYCLES = 2000;      // Six tests of up to ~300 cycles, plus reset.
    localparam thread_t SOLO_THREAD   = 3'd3;
    localparam thread_t PAIR_THREAD   = 3'd5;
    localparam pc_t    ORIGIN_SOLO    = 10'h2a5;
    localparam pc_t    DEST_SOLO      = 10'h155;
    localparam pc_t    ORIGIN_CODES   = 10'h0c3;
    localparam pc_t    DEST_CODES     = 10'h300;
    localparam pc_t    ORIGIN_PAIR    = 10'h1e7;
    localparam pc_t    DEST_LOW       = 10'h011;
    localparam pc_t    DEST_HIGH      = 10'h3ee;

    logic   clock;
    logic   rst_n;
    pc_t    pc;
    flags_t flags;
    logic   io_ready;
    logic   wr_en;
    waddr_t wr_addr;
    wdata_t wr_data;
    logic   jump;
    pc_t    jump_dest;

    branch_unit i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // ----------------------------------------
    // Random source
    // ----------------------------------------
    logic [31:0] lfsr_state = 32'ha7e3_19cc;

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            // Taps 32, 22, 2 and 1.
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic pc_t random_pc();
        logic [31:0] bits;
        bits = take_bits(10);
        return pc_t'(bits[9:0]);
    endfunction

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    pc_t     m_origin [`BR_THREAD_COUNT][`BR_ENTRY_COUNT];
    pc_t     m_dest   [`BR_THREAD_COUNT][`BR_ENTRY_COUNT];
    cond_t   m_cond   [`BR_THREAD_COUNT][`BR_ENTRY_COUNT];
    thread_t m_thread;                                  // Thread of the cycle being driven.
    logic    exp_jump;
    pc_t     exp_dest;
    int      taken_count = 0;
    int      suppressed_count = 0;                      // Matches blocked by io_ready.

    function automatic logic cond_taken(input cond_t code, input flags_t f);
        case (code)
            COND_ALWAYS:       return 1'b1;
            COND_ZERO:         return f.zero;
            COND_NOT_ZERO:     return !f.zero;
            COND_NEGATIVE:     return f.negative;
            COND_NOT_NEGATIVE: return !f.negative;
            COND_CARRY:        return f.carry;
            COND_OVERFLOW:     return f.overflow;
            default:           return 1'b0;
        endcase
    endfunction

    function automatic logic in_window(input waddr_t addr, input waddr_t base);
        return (addr >= base) && (addr < base + waddr_t'(`BR_ENTRY_COUNT));
    endfunction

    always @(posedge clock) begin
        logic found;
        logic blocked;
        pc_t  found_dest;
        if (!rst_n) begin
            for (int t = 0; t < `BR_THREAD_COUNT; t++) begin
                for (int e = 0; e < `BR_ENTRY_COUNT; e++) begin
                    m_origin[t][e] <= '0;
                    m_dest[t][e]   <= '0;
                    m_cond[t][e]   <= COND_NEVER;
                end
            end
            m_thread <= '0;
            exp_jump <= 1'b0;
            exp_dest <= '0;
        end else begin
            found      = 1'b0;
            blocked    = 1'b0;
            found_dest = '0;
            for (int e = 0; e < `BR_ENTRY_COUNT; e++) begin
                if (m_origin[m_thread][e] == pc && cond_taken(m_cond[m_thread][e], flags)) begin
                    blocked = !io_ready;
                    if (io_ready && !found) begin       // First hit has priority.
                        found      = 1'b1;
                        found_dest = m_dest[m_thread][e];
                    end
                end
            end
            if (found) taken_count++;
            if (blocked) suppressed_count++;
            exp_jump <= found;
            if (found) exp_dest <= found_dest;
            if (wr_en && in_window(wr_addr, `BR_ORIGIN_BASE))
                m_origin[m_thread][entry_idx_t'(wr_addr - `BR_ORIGIN_BASE)] <= wr_data[9:0];
            if (wr_en && in_window(wr_addr, `BR_DEST_BASE))
                m_dest[m_thread][entry_idx_t'(wr_addr - `BR_DEST_BASE)] <= wr_data[9:0];
            if (wr_en && in_window(wr_addr, `BR_COND_BASE))
                m_cond[m_thread][entry_idx_t'(wr_addr - `BR_COND_BASE)] <= cond_t'(wr_data[2:0]);
            m_thread <= m_thread + thread_t'(1);        // Wraps after thread 7.
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    int mismatch_count = 0;

    a_jump_check: assert property (@(posedge clock) disable iff (!rst_n) jump === exp_jump)
        else begin
            $display("MISMATCH at %0t: jump is %b, model expects %b", $time,
                     $sampled(jump), $sampled(exp_jump));
            mismatch_count++;
        end

    a_dest_check: assert property (@(posedge clock) disable iff (!rst_n) jump_dest === exp_dest)
        else begin
            $display("MISMATCH at %0t: jump_dest is %h, model expects %h", $time,
                     $sampled(jump_dest), $sampled(exp_dest));
            mismatch_count++;
        end

    int cycle_count = 0;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles.", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    int tests_passed = 0;
    int tests_failed = 0;
    int mismatch_base, taken_base, suppressed_base;

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic drive_issue(input pc_t issue_pc, input logic ready);
        logic [31:0] bits;
        bits     = take_bits(4);
        pc       = issue_pc;
        flags    = flags_t'(bits[3:0]);
        io_ready = ready;
        wr_en    = 1'b0;
    endtask

    // Waits for the thread's slot, then writes one field during it.
    task automatic write_field(input thread_t thread, input waddr_t addr, input pc_t value,
                               input pc_t issue_pc);
        logic [31:0] bits;
        while (m_thread != thread) begin
            drive_issue(random_pc(), 1'b1);
            next_cycle();
        end
        bits = take_bits(6);
        drive_issue(issue_pc, 1'b1);
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = {bits[5:0], value};                  // Upper bits carry noise.
        next_cycle();
        wr_en = 1'b0;
    endtask

    task automatic start_test();
        mismatch_base   = mismatch_count;
        taken_base      = taken_count;
        suppressed_base = suppressed_count;
    endtask

    task automatic end_test(input string name, input logic need_taken, input logic need_stall);
        logic reached;
        drive_issue(random_pc(), 1'b0);
        next_cycle();
        next_cycle();                                   // Last input has now been checked.
        reached = 1'b1;
        if (need_taken && taken_count == taken_base) begin
            $display("Test %s never produced a taken branch.", name);
            reached = 1'b0;
        end
        if (need_stall && suppressed_count == suppressed_base) begin
            $display("Test %s never stalled a matching branch.", name);
            reached = 1'b0;
        end
        if (reached && mismatch_count == mismatch_base) begin
            tests_passed++;
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed, %0d mismatches", name, mismatch_count - mismatch_base);
        end
    endtask

    function automatic pc_t pick_pc();
        logic [31:0] bits;
        bits = take_bits(2);
        case (bits[1:0])
            2'd0:    return ORIGIN_SOLO;
            2'd1:    return ORIGIN_CODES;
            2'd2:    return ORIGIN_PAIR;
            default: return random_pc();
        endcase
    endfunction

    initial begin
        logic [31:0] bits;
        rst_n = 1'b0;
        pc = '0;
        flags = '0;
        io_ready = 1'b0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        repeat (8) @(posedge clock);
        #2 rst_n = 1'b1;

        // Half the slots present the cleared origin so the reset condition is exercised.
        start_test();
        for (int i = 0; i < 100; i++) begin
            bits = take_bits(1);
            drive_issue(bits[0] ? pc_t'(0) : random_pc(), 1'b1);
            next_cycle();
        end
        end_test("reset_quiet", 1'b0, 1'b0);

        // The condition write lands in the thread's own slot with pc at the origin.
        start_test();
        write_field(SOLO_THREAD, `BR_ORIGIN_BASE, ORIGIN_SOLO, random_pc());
        write_field(SOLO_THREAD, `BR_DEST_BASE, DEST_SOLO, random_pc());
        write_field(SOLO_THREAD, `BR_COND_BASE, pc_t'(COND_ALWAYS), ORIGIN_SOLO);
        for (int i = 0; i < 64; i++) begin
            bits = take_bits(1);
            drive_issue(bits[0] ? ORIGIN_SOLO : random_pc(), 1'b1);
            next_cycle();
        end
        end_test("single_entry", 1'b1, 1'b0);

        // Thread t holds condition code t in entry 1.
        start_test();
        for (int t = 0; t < `BR_THREAD_COUNT; t++)
            write_field(thread_t'(t), waddr_t'(`BR_ORIGIN_BASE + 1), ORIGIN_CODES, random_pc());
        for (int t = 0; t < `BR_THREAD_COUNT; t++)
            write_field(thread_t'(t), waddr_t'(`BR_DEST_BASE + 1), DEST_CODES + pc_t'(t),
                        random_pc());
        for (int t = 0; t < `BR_THREAD_COUNT; t++)
            write_field(thread_t'(t), waddr_t'(`BR_COND_BASE + 1), pc_t'(t), random_pc());
        for (int i = 0; i < 200; i++) begin
            drive_issue(ORIGIN_CODES, 1'b1);
            next_cycle();
        end
        end_test("condition_codes", 1'b1, 1'b0);

        start_test();
        write_field(PAIR_THREAD, waddr_t'(`BR_ORIGIN_BASE + 1), ORIGIN_PAIR, random_pc());
        write_field(PAIR_THREAD, waddr_t'(`BR_ORIGIN_BASE + 2), ORIGIN_PAIR, random_pc());
        write_field(PAIR_THREAD, waddr_t'(`BR_DEST_BASE + 1), DEST_LOW, random_pc());
        write_field(PAIR_THREAD, waddr_t'(`BR_DEST_BASE + 2), DEST_HIGH, random_pc());
        write_field(PAIR_THREAD, waddr_t'(`BR_COND_BASE + 1), pc_t'(COND_ALWAYS), random_pc());
        write_field(PAIR_THREAD, waddr_t'(`BR_COND_BASE + 2), pc_t'(COND_ALWAYS), random_pc());
        for (int i = 0; i < 48; i++) begin
            drive_issue(ORIGIN_PAIR, 1'b1);
            next_cycle();
        end
        write_field(PAIR_THREAD, waddr_t'(`BR_COND_BASE + 1), pc_t'(COND_NEVER), random_pc());
        for (int i = 0; i < 48; i++) begin
            drive_issue(ORIGIN_PAIR, 1'b1);
            next_cycle();
        end
        end_test("entry_priority", 1'b1, 1'b0);

        start_test();
        for (int i = 0; i < 80; i++) begin
            bits = take_bits(1);
            drive_issue(ORIGIN_PAIR, bits[0]);
            next_cycle();
        end
        end_test("io_stall", 1'b1, 1'b1);

        // Enabled writes miss every window and in-window writes have wr_en low.
        start_test();
        for (int i = 0; i < 200; i++) begin
            bits = take_bits(12);
            drive_issue(pick_pc(), 1'b1);
            if (i < 120) begin
                wr_en   = bits[11];
                wr_addr = bits[10] ? {1'b1, bits[10:0]} : `BR_ORIGIN_BASE + waddr_t'(bits[3:0]);
                if (bits[11] && !bits[10])
                    wr_addr = `BR_COND_BASE + waddr_t'(`BR_ENTRY_COUNT) + waddr_t'(bits[1:0]);
                wr_data = wdata_t'(take_bits(16));
            end
            next_cycle();
        end
        end_test("ignored_writes", 1'b1, 1'b0);

        $display("Tests passed: %0d, tests failed: %0d, mismatches: %0d",
                 tests_passed, tests_failed, mismatch_count);
        if (tests_failed == 0 && mismatch_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== thread_field_store.sv ====
// Per-thread field store
`timescale 1ns/1ps
`include "branch_defs.svh"

module thread_field_store
    import branch_map_pkg::*;
#(
    parameter type payload_t = pc_t                 // PC or condition payload.
)
(
    input  logic     clock,
    input  logic     rst_n,
    input  logic     we,                            // Write strobe for this field.
    input  thread_t  thread,                        // Thread copy to read and write.
    input  payload_t wdata,
    output payload_t rdata
);

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    payload_t values [`BR_THREAD_COUNT];            // One value per hardware thread.

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < `BR_THREAD_COUNT; i++) begin
                values[i] <= payload_t'(0);         // Conditions clear to never.
            end
        end else if (we) begin
            values[thread] <= wdata;                // Lands in the issuing thread's copy.
        end
    end

    // Same-cycle writes are not visible here until the thread issues again.
    assign rdata = values[thread];

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    // The sequencer must never present a thread beyond the store depth.
    a_thread_in_range: assert property (
        @(posedge clock) disable iff (!rst_n)
        !$isunknown(thread) && (int'(thread) < `BR_THREAD_COUNT)
    ) else $error("Thread index %0d outside the store.", thread);

endmodule
